/* i2c_slv_rx.f */
i2c_rx_pkg.sv
i2c_line_sync.sv
i2c_addr_match.sv
i2c_rx_shifter.sv
i2c_slv_rx.sv
tb_i2c_slv_rx_asserts.sv
tb_i2c_slv_rx.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_i2c_slv_rx -f i2c_slv_rx.f \
    -o tb_i2c_slv_rx > build.log 2>&1 \
    && { ./obj_dir/tb_i2c_slv_rx > sim.log 2>&1 || echo "Simulation failed" >> sim.log; } \
    || { cat build.log; echo "Simulation failed" >> sim.log; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* tb_i2c_slv_rx.sv */
`timescale 1ns/10ps

module tb_i2c_slv_rx;

    import i2c_rx_pkg::*;

    localparam int STEAL_BITS = 2;
    localparam int WAIT_LIMIT = 100;

    logic     i2c_clk = 1'b0;
    logic     i2c_rst_n;
    logic     scl;
    logic     sda_drv;
    logic     sda;
    slv_cfg_t cfg;
    logic     sda_out;
    rx_push_t rx_push;
    logic     gen_call_rcvd;

    logic [31:0] rng_state;
    rx_byte_t    exp_q[$];
    int          gcall_seen = 0;
    int          gcall_expect;

    // either side of the open-drain bus can pull low
    assign sda = sda_drv & sda_out;

    i2c_slv_rx #(
        .ADDRESS_STEALING (STEAL_BITS)
    ) u_i2c_slv_rx (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .scl           (scl),
        .sda           (sda),
        .cfg           (cfg),
        .sda_out       (sda_out),
        .rx_push       (rx_push),
        .gen_call_rcvd (gen_call_rcvd)
    );

    always #5 i2c_clk = ~i2c_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = rand32();
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // acked for a write whose bits above the stolen ones match sar or for a general call
    function automatic logic expect_addr_ack(input slv_cfg_t c, input rx_byte_t a);
        logic [6:0] diff;
        logic       sar_ok;
        logic       gcall_ok;
        diff     = a[7:1] ^ c.sar;
        sar_ok   = ((diff >> STEAL_BITS) == 7'd0) && (a[0] == 1'b0);
        gcall_ok = c.ack_general_call && (a == 8'h00);
        return c.enable && (sar_ok || gcall_ok);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge i2c_clk);
    endtask

    // one scl period with sda moving in the middle of the low phase
    task automatic clock_bit(input logic bit_val, output logic sampled);
        int low_len;
        int high_len;
        low_len  = rand_range(8, 15);
        high_len = rand_range(8, 15);
        idle_cycles(low_len / 2);
        sda_drv = bit_val;
        idle_cycles(low_len - low_len / 2);
        scl = 1'b1;
        idle_cycles(high_len / 2);
        sampled = sda;
        idle_cycles(high_len - high_len / 2);
        scl = 1'b0;
    endtask

    task automatic send_start();
        int len;
        // a repeated start releases sda and raises scl first
        if (scl == 1'b0) begin
            len = rand_range(8, 15);
            idle_cycles(len / 2);
            sda_drv = 1'b1;
            idle_cycles(len - len / 2);
            scl = 1'b1;
        end
        idle_cycles(rand_range(8, 15));
        sda_drv = 1'b0;
        idle_cycles(rand_range(8, 15));
        scl = 1'b0;
    endtask

    task automatic send_stop();
        int len;
        len = rand_range(8, 15);
        idle_cycles(len / 2);
        sda_drv = 1'b0;
        idle_cycles(len - len / 2);
        scl = 1'b1;
        idle_cycles(rand_range(8, 15));
        sda_drv = 1'b1;
        idle_cycles(rand_range(8, 15));
    endtask

    task automatic write_byte(input rx_byte_t value);
        logic unused_line;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(value[i], unused_line);
        end
    endtask

    task automatic read_ack(output logic acked);
        logic line;
        clock_bit(1'b1, line);
        acked = ~line;
    endtask

    task automatic check_ack(input string kind, input rx_byte_t value,
                             input logic exp_ack, input logic got_ack);
        assert (got_ack == exp_ack)
            else fail_run($sformatf("MISMATCH time=%0t: %s byte %02h expected %s, got %s",
                                    $time, kind, value, exp_ack ? "ACK" : "NACK",
                                    got_ack ? "ACK" : "NACK"));
    endtask

    task automatic wait_push_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < WAIT_LIMIT)) begin
            @(negedge i2c_clk);
            n++;
        end
        assert (exp_q.size() == 0)
            else fail_run("timeout: an acknowledged data byte was never pushed");
    endtask

    task automatic wait_gcall();
        int n;
        n = 0;
        while ((gcall_seen < gcall_expect) && (n < WAIT_LIMIT)) begin
            @(negedge i2c_clk);
            n++;
        end
        assert (gcall_seen >= gcall_expect)
            else fail_run("timeout: gen_call_rcvd did not pulse for a general call");
        assert (gcall_seen == gcall_expect)
            else fail_run($sformatf("MISMATCH time=%0t: %0d gen_call_rcvd pulses, expected %0d",
                                    $time, gcall_seen, gcall_expect));
    endtask

    // cfg only changes while the bus is idle
    task automatic set_cfg(input logic enable, input logic gcall, input logic dnack);
        cfg.enable           = enable;
        cfg.ack_general_call = gcall;
        cfg.data_nack        = dnack;
        idle_cycles(4);
    endtask

    task automatic send_address(input rx_byte_t addr, output logic addressed);
        logic exp_ack;
        logic acked;
        exp_ack = expect_addr_ack(cfg, addr);
        if (exp_ack && cfg.ack_general_call && (addr == 8'h00)) begin
            gcall_expect++;
        end
        write_byte(addr);
        read_ack(acked);
        check_ack("address", addr, exp_ack, acked);
        wait_gcall();
        addressed = exp_ack;
    endtask

    task automatic send_data(input int n, input logic addressed);
        logic [31:0] r;
        rx_byte_t    data;
        logic        exp_ack;
        logic        acked;
        for (int i = 0; i < n; i++) begin
            r       = rand32();
            data    = r[7:0];
            exp_ack = addressed && cfg.enable && !cfg.data_nack;
            if (exp_ack) begin
                exp_q.push_back(data);
            end
            write_byte(data);
            read_ack(acked);
            check_ack("data", data, exp_ack, acked);
            wait_push_drain();
        end
    endtask

    task automatic run_transfer(input rx_byte_t addr, input int n_data);
        logic addressed;
        send_start();
        send_address(addr, addressed);
        send_data(n_data, addressed);
        send_stop();
        wait_gcall();
    endtask

    task automatic run_restart(input rx_byte_t second_addr);
        logic        addressed;
        logic        unused_line;
        logic [31:0] r;
        int          k;
        send_start();
        send_address({cfg.sar, 1'b0}, addressed);
        r = rand32();
        k = rand_range(1, 7);
        // these bits of a cut-short data byte are never pushed
        for (int i = 0; i < k; i++) begin
            clock_bit(r[i], unused_line);
        end
        send_start();
        send_address(second_addr, addressed);
        send_data(rand_range(1, 3), addressed);
        send_stop();
        wait_gcall();
    endtask

    // strobes are sampled on the clock edge before the DUT updates them
    always @(posedge i2c_clk) begin
        rx_byte_t want;
        if (i2c_rst_n && gen_call_rcvd) begin
            gcall_seen++;
        end
        if (i2c_rst_n && rx_push.valid) begin
            assert (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (rx_push.data == want)
                    else fail_run($sformatf("MISMATCH time=%0t: pushed %02h, expected %02h",
                                            $time, rx_push.data, want));
            end else begin
                fail_run("rx_push strobed while no byte was expected");
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [6:0]  flip;
        rng_state    = 32'h71c5;
        gcall_expect = 0;
        i2c_rst_n    = 1'b0;
        scl          = 1'b1;
        sda_drv      = 1'b1;
        cfg          = '0;
        repeat (16) @(negedge i2c_clk);
        i2c_rst_n = 1'b1;
        idle_cycles(8);

        r = rand32();
        // sar[6] set keeps address 0 outside the stolen range
        cfg.sar = {1'b1, r[5:0]};

        set_cfg(1'b1, 1'b0, 1'b0);
        repeat (4) begin
            run_transfer({cfg.sar, 1'b0}, rand_range(1, 6));
        end

        // wrong address and read requests
        run_transfer({cfg.sar ^ (7'd1 << rand_range(2, 6)), 1'b0}, 2);
        run_transfer({cfg.sar, 1'b1}, 2);
        run_transfer({cfg.sar ^ 7'd2, 1'b1}, 1);

        // even passes flip only stolen bits and odd ones flip a compared bit too
        for (int i = 0; i < 8; i++) begin
            r    = rand32();
            flip = r[6:0];
            if (i % 2 == 0) begin
                flip = flip & 7'h03;
            end else begin
                flip = flip | (7'd1 << rand_range(2, 6));
            end
            run_transfer({cfg.sar ^ flip, 1'b0}, rand_range(1, 3));
        end

        set_cfg(1'b1, 1'b1, 1'b0);
        run_transfer(8'h00, 2);
        run_transfer({cfg.sar, 1'b0}, 1);
        run_transfer(8'h00, 3);
        set_cfg(1'b1, 1'b0, 1'b0);
        run_transfer(8'h00, 1);

        set_cfg(1'b1, 1'b1, 1'b1);
        run_transfer({cfg.sar, 1'b0}, 3);
        run_transfer(8'h00, 2);
        set_cfg(1'b0, 1'b1, 1'b0);
        run_transfer({cfg.sar, 1'b0}, 2);
        run_transfer(8'h00, 1);

        // repeated start in the middle of a data byte
        set_cfg(1'b1, 1'b1, 1'b0);
        run_restart({cfg.sar ^ 7'd1, 1'b0});
        run_restart(8'h00);
        run_restart({cfg.sar ^ 7'h10, 1'b0});

        $display("Simulation passed");
        $finish;
    end

endmodule

/* tb_i2c_slv_rx_asserts.sv */
`timescale 1ns/10ps

module tb_i2c_slv_rx_asserts (
    input logic                  i2c_clk,
    input logic                  i2c_rst_n,
    input logic                  sda_out,
    input logic                  gen_call_rcvd,
    input i2c_rx_pkg::rx_push_t  rx_push,
    input i2c_rx_pkg::rx_state_e state
);

    import i2c_rx_pkg::*;

    // a byte strobe never stretches into the next cycle
    a_push_single: assert property (
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        rx_push.valid |=> !rx_push.valid
    ) else $error("rx_push.valid stayed high for more than one cycle");

    // the slave leaves the bus alone while idle
    a_idle_release: assert property (
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        (state == IDLE) |-> sda_out
    ) else $error("sda_out pulled low while the shifter is idle");

    a_gcall_no_push: assert property (
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        !(gen_call_rcvd && rx_push.valid)
    ) else $error("gen_call_rcvd and rx_push.valid high in the same cycle");

    // sda is only driven in the ninth clock
    a_ack_slot_only: assert property (
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        (state != RX_ACK) |-> sda_out
    ) else $error("sda_out pulled low outside the ack slot");

endmodule

bind i2c_slv_rx tb_i2c_slv_rx_asserts u_asserts (
    .i2c_clk       (i2c_clk),
    .i2c_rst_n     (i2c_rst_n),
    .sda_out       (sda_out),
    .gen_call_rcvd (gen_call_rcvd),
    .rx_push       (rx_push),
    .state         (u_rx_shifter.state)
);

/* i2c_slv_rx.sv */
`timescale 1ns/10ps

module i2c_slv_rx #(
    parameter int ADDRESS_STEALING = 0
) (
    input  logic                 i2c_clk,
    input  logic                 i2c_rst_n,
    input  logic                 scl,
    input  logic                 sda,
    input  i2c_rx_pkg::slv_cfg_t cfg,
    output logic                 sda_out,
    output i2c_rx_pkg::rx_push_t rx_push,
    output logic                 gen_call_rcvd
);

    import i2c_rx_pkg::*;

    logic     sda_s;
    logic     scl_rise;
    logic     scl_fall;
    logic     start_det;
    logic     stop_det;
    rx_byte_t shift_byte;
    logic     addr_phase;
    logic     addr_hit;
    logic     gcall_hit;

    i2c_line_sync u_line_sync (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n),
        .scl       (scl),
        .sda       (sda),
        .sda_s     (sda_s),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    i2c_rx_shifter u_rx_shifter (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .sda_s         (sda_s),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_det     (start_det),
        .stop_det      (stop_det),
        .cfg           (cfg),
        .addr_hit      (addr_hit),
        .gcall_hit     (gcall_hit),
        .shift_byte    (shift_byte),
        .addr_phase    (addr_phase),
        .sda_out       (sda_out),
        .rx_push       (rx_push),
        .gen_call_rcvd (gen_call_rcvd)
    );

    i2c_addr_match #(
        .ADDRESS_STEALING (ADDRESS_STEALING)
    ) u_addr_match (
        .shift_byte (shift_byte),
        .addr_phase (addr_phase),
        .cfg        (cfg),
        .addr_hit   (addr_hit),
        .gcall_hit  (gcall_hit)
    );

endmodule

/* i2c_rx_shifter.sv */
`timescale 1ns/10ps

module i2c_rx_shifter (
    input  logic                 i2c_clk,
    input  logic                 i2c_rst_n,
    input  logic                 sda_s,
    input  logic                 scl_rise,
    input  logic                 scl_fall,
    input  logic                 start_det,
    input  logic                 stop_det,
    input  i2c_rx_pkg::slv_cfg_t cfg,
    input  logic                 addr_hit,
    input  logic                 gcall_hit,
    output i2c_rx_pkg::rx_byte_t shift_byte,
    output logic                 addr_phase,
    output logic                 sda_out,
    output i2c_rx_pkg::rx_push_t rx_push,
    output logic                 gen_call_rcvd
);

    import i2c_rx_pkg::*;

    localparam bit_cnt_t CNT_LOAD = bit_cnt_t'(BYTE_BITS);

    rx_state_e state;
    bit_cnt_t  bit_cnt;
    logic [2:0] bit_pos;
    logic      bit_seen;
    logic      addressed;
    logic      push_valid;
    logic      ack_ok;
    logic      last_fall;

    // the byte after start is the address until its ack slot is over
    assign addr_phase = ~addressed & ((state == RX_SHIFT) | (state == RX_ACK));

    assign ack_ok = addr_phase ? (cfg.enable & (addr_hit | gcall_hit))
                               : (cfg.enable & ~cfg.data_nack);

    // falling edge that closes the eighth data bit
    assign last_fall = scl_fall & bit_seen & (bit_cnt == 4'd1);

    assign bit_pos = 3'(bit_cnt - 4'd1);

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            state         <= IDLE;
            bit_cnt       <= CNT_LOAD;
            bit_seen      <= 1'b0;
            addressed     <= 1'b0;
            sda_out       <= 1'b1;
            push_valid    <= 1'b0;
            gen_call_rcvd <= 1'b0;
        end else begin
            push_valid    <= 1'b0;
            gen_call_rcvd <= 1'b0;
            if (stop_det) begin
                state     <= IDLE;
                bit_cnt   <= CNT_LOAD;
                bit_seen  <= 1'b0;
                addressed <= 1'b0;
                sda_out   <= 1'b1;
            end else if (start_det) begin
                // repeated start drops any partial byte
                state     <= RX_SHIFT;
                bit_cnt   <= CNT_LOAD;
                bit_seen  <= 1'b0;
                addressed <= 1'b0;
                sda_out   <= 1'b1;
            end else begin
                case (state)
                    RX_SHIFT: begin
                        if (scl_rise) begin
                            bit_seen <= 1'b1;
                        end
                        // the first fall after start carries no bit
                        if (scl_fall && bit_seen) begin
                            bit_seen <= 1'b0;
                            bit_cnt  <= bit_cnt - 4'd1;
                        end
                        if (last_fall) begin
                            state         <= RX_ACK;
                            sda_out       <= ~ack_ok;
                            push_valid    <= ~addr_phase & ack_ok;
                            gen_call_rcvd <= addr_phase & ack_ok & gcall_hit;
                        end
                    end
                    RX_ACK: begin
                        // release sda once the ninth clock goes low
                        if (scl_fall) begin
                            sda_out <= 1'b1;
                            bit_cnt <= CNT_LOAD;
                            if (addr_phase && sda_out) begin
                                state <= RX_WAIT;
                            end else begin
                                state <= RX_SHIFT;
                                if (addr_phase) begin
                                    addressed <= 1'b1;
                                end
                            end
                        end
                    end
                    // idle and wait only leave on start or stop
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // msb first, bit position follows the counter
    always_ff @(posedge i2c_clk) begin
        if ((state == RX_SHIFT) && scl_rise) begin
            shift_byte[bit_pos] <= sda_s;
        end
    end

    // shift_byte is stable through the ack slot
    assign rx_push.valid = push_valid;
    assign rx_push.data  = shift_byte;

endmodule

/* i2c_addr_match.sv */
`timescale 1ns/10ps

module i2c_addr_match #(
    parameter int ADDRESS_STEALING = 0
) (
    input  i2c_rx_pkg::rx_byte_t shift_byte,
    input  logic                 addr_phase,
    input  i2c_rx_pkg::slv_cfg_t cfg,
    output logic                 addr_hit,
    output logic                 gcall_hit
);

    import i2c_rx_pkg::*;

    // low address bits left out of the compare
    localparam i2c_addr7_t STEAL_MASK = ~i2c_addr7_t'((1 << ADDRESS_STEALING) - 1);

    logic sar_equal;
    logic write_bit;

    assign sar_equal = (shift_byte[7:1] & STEAL_MASK) == (cfg.sar & STEAL_MASK);

    // reads are not supported, r/w = 1 never matches
    assign write_bit = ~shift_byte[0];

    assign addr_hit  = addr_phase & sar_equal & write_bit;
    assign gcall_hit = addr_phase & cfg.ack_general_call & (shift_byte == GCALL_ADDR);

endmodule

/* i2c_line_sync.sv */
`timescale 1ns/10ps

module i2c_line_sync (
    input  logic i2c_clk,
    input  logic i2c_rst_n,
    input  logic scl,
    input  logic sda,
    output logic sda_s,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_d;
    logic       sda_d;

    // two-stage synchronizers, the idle bus is high
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
        end
    end

    // previous synchronized values for edge detection
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_d <= 1'b1;
            sda_d <= 1'b1;
        end else begin
            scl_d <= scl_sync[1];
            sda_d <= sda_sync[1];
        end
    end

    // registered pulses, three cycles behind the pins
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_rise  <= scl_sync[1] & ~scl_d;
            scl_fall  <= ~scl_sync[1] & scl_d;
            // sda may only move with scl high for start and stop
            start_det <= ~sda_sync[1] & sda_d & scl_sync[1] & scl_d;
            stop_det  <= sda_sync[1] & ~sda_d & scl_sync[1] & scl_d;
        end
    end

    // sda_d lines up with the registered pulses
    assign sda_s = sda_d;

endmodule

/* i2c_rx_pkg.sv */
package i2c_rx_pkg;

    // data bits per byte, the ninth clock is the ack slot
    localparam int BYTE_BITS = 8;

    typedef logic [7:0] rx_byte_t;
    typedef logic [6:0] i2c_addr7_t;

    // counts 8 down to 0, zero is the ack slot
    typedef logic [3:0] bit_cnt_t;

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        RX_SHIFT = 2'b01,
        RX_ACK   = 2'b10,
        RX_WAIT  = 2'b11
    } rx_state_e;

    // static settings, held stable while the bus is active
    typedef struct packed {
        logic       enable;
        logic       ack_general_call;
        logic       data_nack;
        i2c_addr7_t sar;
    } slv_cfg_t;

    // one received byte, valid is a single-cycle strobe
    typedef struct packed {
        logic     valid;
        rx_byte_t data;
    } rx_push_t;

    // general call is address 0 with r/w = 0
    localparam rx_byte_t GCALL_ADDR = 8'h00;

endpackage
